//--- hdl/mini_cluster_pkg.sv
// ***************************************************************************
// Shared widths, narrow request and response structs, cluster address map
// and peripheral register offsets
// ***************************************************************************
`default_nettype none

package mini_cluster_pkg;

  // Bus widths
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned ByteOffsWidth = $clog2(StrbWidth);

  // Upper bound on the cluster size, sizes the interrupt field in a word
  localparam int unsigned NrCoresMax = 8;

  // Narrow request, one word per transaction
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } narrow_req_t;

  // Narrow response
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 error;
  } narrow_resp_t;

  // Address map, both windows are naturally aligned powers of two
  localparam logic [AddrWidth-1:0] TcdmBase   = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TcdmSize   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] PeriphBase = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] PeriphSize = 32'h0000_0100;

  localparam int unsigned PeriphOffsWidth = $clog2(PeriphSize);

  // Peripheral register offsets
  // Entry point for the cores after boot
  localparam logic [PeriphOffsWidth-1:0] ScratchEntryOffs = 8'h00;
  localparam logic [PeriphOffsWidth-1:0] Scratch1Offs     = 8'h04;
  // CLINT software interrupts, write one to set
  localparam logic [PeriphOffsWidth-1:0] ClintSetOffs     = 8'h08;
  // write one to clear
  localparam logic [PeriphOffsWidth-1:0] ClintClearOffs   = 8'h0C;
  localparam logic [PeriphOffsWidth-1:0] ClintStatusOffs  = 8'h10;
  // Read only
  localparam logic [PeriphOffsWidth-1:0] HartBaseIdOffs   = 8'h14;

endpackage

`default_nettype wire

//--- hdl/narrow_demux.sv
// ***************************************************************************
// Narrow port demux: single outstanding request, address decode,
// target strobe and held response with unmapped address error
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module narrow_demux (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  mini_cluster_pkg::narrow_req_t            narrow_req_i,
  input  logic                                     narrow_req_valid_i,
  output logic                                     narrow_req_ready_o,
  output mini_cluster_pkg::narrow_resp_t           narrow_resp_o,
  output logic                                     narrow_resp_valid_o,
  input  logic                                     narrow_resp_ready_i,
  output mini_cluster_pkg::narrow_req_t            periph_req_o,
  output logic                                     periph_sel_o,
  input  logic [mini_cluster_pkg::DataWidth-1:0]   periph_rdata_i,
  output mini_cluster_pkg::narrow_req_t            tcdm_req_o,
  output logic                                     tcdm_sel_o,
  input  logic [mini_cluster_pkg::DataWidth-1:0]   tcdm_rdata_i
);

  typedef enum logic [1:0] {
    s_idle,
    s_issue,
    s_resp
  } state_e;

  state_e                         state_q, state_d;
  mini_cluster_pkg::narrow_req_t  req_q;
  mini_cluster_pkg::narrow_resp_t resp_live, resp_held_q;
  logic                           hit_periph, hit_tcdm;
  logic                           to_periph_q, to_tcdm_q, err_q;
  logic                           first_q;
  logic                           req_fire, resp_fire;

  // Window decode on the incoming address
  assign hit_periph = (narrow_req_i.addr & ~(mini_cluster_pkg::PeriphSize - 1))
                      == mini_cluster_pkg::PeriphBase;
  assign hit_tcdm   = (narrow_req_i.addr & ~(mini_cluster_pkg::TcdmSize - 1))
                      == mini_cluster_pkg::TcdmBase;

  // Handshakes
  assign narrow_req_ready_o  = (state_q == s_idle);
  assign narrow_resp_valid_o = (state_q == s_resp);
  assign req_fire            = narrow_req_valid_i && narrow_req_ready_o;
  assign resp_fire           = narrow_resp_valid_o && narrow_resp_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      s_idle: begin
        if (req_fire) begin
          state_d = s_issue;
        end
      end
      s_issue: begin
        state_d = s_resp;
      end
      s_resp: begin
        if (resp_fire) begin
          state_d = s_idle;
        end
      end
      default: begin
        state_d = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= s_idle;
      to_periph_q <= 1'b0;
      to_tcdm_q   <= 1'b0;
      err_q       <= 1'b0;
      first_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      // First response cycle still reads the target directly
      first_q <= (state_q == s_issue);
      if (req_fire) begin
        to_periph_q <= hit_periph;
        to_tcdm_q   <= hit_tcdm && !hit_periph;
        err_q       <= !hit_periph && !hit_tcdm;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= narrow_req_i;
    end
    if (first_q) begin
      resp_held_q <= resp_live;
    end
  end

  // Exactly one target strobed in the issue cycle, none on an error
  assign periph_req_o = req_q;
  assign tcdm_req_o   = req_q;
  assign periph_sel_o = (state_q == s_issue) && to_periph_q;
  assign tcdm_sel_o   = (state_q == s_issue) && to_tcdm_q;

  always_comb begin
    resp_live.error = err_q;
    if (err_q) begin
      resp_live.rdata = '0;
    end else if (to_periph_q) begin
      resp_live.rdata = periph_rdata_i;
    end else begin
      resp_live.rdata = tcdm_rdata_i;
    end
  end

  assign narrow_resp_o = first_q ? resp_live : resp_held_q;

endmodule

`default_nettype wire

//--- hdl/cluster_periph.sv
// ***************************************************************************
// Cluster peripherals: entry point and scratch registers, CLINT
// software interrupt set/clear/status and the hart base id
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cluster_periph #(
  parameter int unsigned NrCores    = 4,
  parameter int unsigned HartBaseId = 0
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  mini_cluster_pkg::narrow_req_t          req_i,
  input  logic                                   sel_i,
  output logic [mini_cluster_pkg::DataWidth-1:0] rdata_o,
  output logic [NrCores-1:0]                     msip_o
);

  logic [mini_cluster_pkg::PeriphOffsWidth-1:0] offs;
  logic                                         wr_en;
  logic [mini_cluster_pkg::DataWidth-1:0]       scratch_entry_q, scratch1_q;
  logic [mini_cluster_pkg::DataWidth-1:0]       rdata_d, rdata_q;
  logic [mini_cluster_pkg::NrCoresMax-1:0]      irq_field;
  logic [NrCores-1:0]                           pending_q, pending_d;

  // Merge the strobed bytes of a write into the old word
  function automatic logic [mini_cluster_pkg::DataWidth-1:0] strb_merge(
    input logic [mini_cluster_pkg::DataWidth-1:0] old_word,
    input logic [mini_cluster_pkg::DataWidth-1:0] new_word,
    input logic [mini_cluster_pkg::StrbWidth-1:0] strb
  );
    logic [mini_cluster_pkg::DataWidth-1:0] merged;
    merged = old_word;
    for (int b = 0; b < mini_cluster_pkg::StrbWidth; b++) begin
      if (strb[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  // Word aligned offset inside the peripheral window
  assign offs = {req_i.addr[mini_cluster_pkg::PeriphOffsWidth-1:mini_cluster_pkg::ByteOffsWidth],
                 {mini_cluster_pkg::ByteOffsWidth{1'b0}}};
  assign wr_en = sel_i && req_i.write;

  // Interrupt bits sit in the low byte, only NrCores of them exist
  assign irq_field = req_i.wdata[mini_cluster_pkg::NrCoresMax-1:0];

  always_comb begin
    pending_d = pending_q;
    if (wr_en && (offs == mini_cluster_pkg::ClintSetOffs)) begin
      pending_d = pending_q | irq_field[NrCores-1:0];
    end
    // Clear is applied last so it wins
    if (wr_en && (offs == mini_cluster_pkg::ClintClearOffs)) begin
      pending_d = pending_d & ~irq_field[NrCores-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_entry_q <= '0;
      scratch1_q      <= '0;
      pending_q       <= '0;
    end else begin
      pending_q <= pending_d;
      if (wr_en && (offs == mini_cluster_pkg::ScratchEntryOffs)) begin
        scratch_entry_q <= strb_merge(scratch_entry_q, req_i.wdata, req_i.strb);
      end
      if (wr_en && (offs == mini_cluster_pkg::Scratch1Offs)) begin
        scratch1_q <= strb_merge(scratch1_q, req_i.wdata, req_i.strb);
      end
    end
  end

  // Read mux, writes and unknown offsets give zero
  always_comb begin
    rdata_d = '0;
    if (!req_i.write) begin
      unique case (offs)
        mini_cluster_pkg::ScratchEntryOffs: rdata_d = scratch_entry_q;
        mini_cluster_pkg::Scratch1Offs:     rdata_d = scratch1_q;
        mini_cluster_pkg::ClintStatusOffs:  rdata_d[NrCores-1:0] = pending_q;
        mini_cluster_pkg::HartBaseIdOffs:   rdata_d = HartBaseId;
        default:                            rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;
  assign msip_o  = pending_q;

endmodule

`default_nettype wire

//--- hdl/tcdm_sram.sv
// ***************************************************************************
// Tightly coupled data memory, word addressed, byte strobe writes
// and registered read data
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tcdm_sram #(
  parameter int unsigned TcdmWords = 1024
) (
  input  logic                                   clk_i,
  input  mini_cluster_pkg::narrow_req_t          req_i,
  input  logic                                   sel_i,
  output logic [mini_cluster_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = (TcdmWords > 1) ? $clog2(TcdmWords) : 1;
  localparam int unsigned WordAddrWidth =
    mini_cluster_pkg::AddrWidth - mini_cluster_pkg::ByteOffsWidth;

  logic [mini_cluster_pkg::DataWidth-1:0] mem_q [TcdmWords];
  logic [WordAddrWidth-1:0]               word_addr;
  logic [IdxWidth-1:0]                    idx;
  logic [mini_cluster_pkg::DataWidth-1:0] rdata_q;

  // Drop the byte offset, then wrap on the memory depth
  assign word_addr = req_i.addr[mini_cluster_pkg::AddrWidth-1:mini_cluster_pkg::ByteOffsWidth];
  assign idx       = IdxWidth'(word_addr % TcdmWords);

  // Byte lanes written under the strobe
  always_ff @(posedge clk_i) begin
    if (sel_i && req_i.write) begin
      for (int b = 0; b < mini_cluster_pkg::StrbWidth; b++) begin
        if (req_i.strb[b]) begin
          mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data one cycle after the strobe, held until the next one
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (req_i.write) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/mini_cluster.sv
// ***************************************************************************
// Mini cluster top level: narrow port demux, peripherals and TCDM
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module mini_cluster #(
  parameter int unsigned NrCores    = 4,
  parameter int unsigned HartBaseId = 0,
  parameter int unsigned TcdmWords  = 1024
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  mini_cluster_pkg::narrow_req_t  narrow_req_i,
  input  logic                           narrow_req_valid_i,
  output logic                           narrow_req_ready_o,
  output mini_cluster_pkg::narrow_resp_t narrow_resp_o,
  output logic                           narrow_resp_valid_o,
  input  logic                           narrow_resp_ready_i,
  output logic [NrCores-1:0]             msip_o
);

  // Target side of the demux
  mini_cluster_pkg::narrow_req_t          periph_req, tcdm_req;
  logic                                   periph_sel, tcdm_sel;
  logic [mini_cluster_pkg::DataWidth-1:0] periph_rdata, tcdm_rdata;

  narrow_demux i_narrow_demux (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .narrow_req_i        (narrow_req_i),
    .narrow_req_valid_i  (narrow_req_valid_i),
    .narrow_req_ready_o  (narrow_req_ready_o),
    .narrow_resp_o       (narrow_resp_o),
    .narrow_resp_valid_o (narrow_resp_valid_o),
    .narrow_resp_ready_i (narrow_resp_ready_i),
    .periph_req_o        (periph_req),
    .periph_sel_o        (periph_sel),
    .periph_rdata_i      (periph_rdata),
    .tcdm_req_o          (tcdm_req),
    .tcdm_sel_o          (tcdm_sel),
    .tcdm_rdata_i        (tcdm_rdata)
  );

  cluster_periph #(
    .NrCores    (NrCores),
    .HartBaseId (HartBaseId)
  ) i_cluster_periph (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (periph_req),
    .sel_i    (periph_sel),
    .rdata_o  (periph_rdata),
    .msip_o   (msip_o)
  );

  tcdm_sram #(
    .TcdmWords (TcdmWords)
  ) i_tcdm_sram (
    .clk_i   (clk_i),
    .req_i   (tcdm_req),
    .sel_i   (tcdm_sel),
    .rdata_o (tcdm_rdata)
  );

endmodule

`default_nettype wire

//--- test/mini_cluster_asserts.sv
// ***************************************************************************
// Concurrent checks on the narrow port handshake and the interrupt outputs
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module mini_cluster_asserts #(
  parameter int unsigned NrCores = 4
) (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input mini_cluster_pkg::narrow_req_t  req_i,
  input logic                           req_valid_i,
  input logic                           req_ready_i,
  input mini_cluster_pkg::narrow_resp_t resp_i,
  input logic                           resp_valid_i,
  input logic                           resp_ready_i,
  input logic [NrCores-1:0]             msip_i
);

  // Requester keeps its request until the cluster takes it
  req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("narrow request changed before it was accepted");

  resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else $error("narrow response changed under back-pressure");

  // Ready stays low from acceptance until the response transfers
  no_accept_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i || $past(req_valid_i && req_ready_i) |-> !req_ready_i)
    else $error("request ready high while a request is outstanding");

  msip_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (msip_i == '0))
    else $error("software interrupt raised right after reset");

endmodule

bind mini_cluster mini_cluster_asserts #(
  .NrCores (NrCores)
) i_mini_cluster_asserts (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .req_i        (narrow_req_i),
  .req_valid_i  (narrow_req_valid_i),
  .req_ready_i  (narrow_req_ready_o),
  .resp_i       (narrow_resp_o),
  .resp_valid_i (narrow_resp_valid_o),
  .resp_ready_i (narrow_resp_ready_i),
  .msip_i       (msip_o)
);

`default_nettype wire

//--- test/testharness.sv
// ***************************************************************************
// Mini cluster testbench with clock and reset, file driven narrow
// transactions with random response stalls, checks and the closing summary
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module testharness;

  localparam int unsigned NrCores       = 4;
  localparam int unsigned HartBaseId    = 32'h10;
  localparam int unsigned TcdmWords     = 256;
  localparam int unsigned NrCols        = 7;
  localparam int unsigned MaxRows       = 64;
  localparam int unsigned TimeoutCycles = 100;
  localparam int unsigned RespLatency   = 2;
  localparam logic [31:0] OpEnd         = 32'hF;

  logic                           clk, arst_n;
  mini_cluster_pkg::narrow_req_t  req;
  logic                           req_valid, req_ready;
  mini_cluster_pkg::narrow_resp_t resp;
  logic                           resp_valid, resp_ready;
  logic [NrCores-1:0]             msip;
  logic [31:0]                    vectors [MaxRows*NrCols];
  logic [15:0]                    lfsr_q;
  int unsigned                    cycle_cnt, nr_tests, nr_pass, nr_errors;
  bit                             timed_out;

  mini_cluster #(
    .NrCores    (NrCores),
    .HartBaseId (HartBaseId),
    .TcdmWords  (TcdmWords)
  ) UUT (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .narrow_req_i        (req),
    .narrow_req_valid_i  (req_valid),
    .narrow_req_ready_o  (req_ready),
    .narrow_resp_o       (resp),
    .narrow_resp_valid_o (resp_valid),
    .narrow_resp_ready_i (resp_ready),
    .msip_o              (msip)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  task automatic draw_bits(input int unsigned n, output int unsigned value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value  = (value << 1) | 32'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Returns 1 ns after the edge, where inputs change and outputs are settled
  task automatic step_cycle();
    @(posedge clk);
    cycle_cnt++;
    #1;
  endtask

  task automatic report_value_error(input string where, input string name,
                                    input logic [31:0] expected, input logic [31:0] actual);
    $display("FAIL %s %s expected 0x%h got 0x%h", where, name, expected, actual);
    nr_errors++;
  endtask

  task automatic report_test_result(input string name, input int unsigned errs_before);
    if (nr_errors == errs_before) begin
      nr_pass++;
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, nr_errors - errs_before);
    end
  endtask

  task automatic do_transfer(
    input  mini_cluster_pkg::narrow_req_t  txn,
    input  string                          where,
    output mini_cluster_pkg::narrow_resp_t got,
    output int unsigned                    arrival
  );
    int unsigned                    waited;
    int unsigned                    stalls;
    int unsigned                    accept_cycle;
    mini_cluster_pkg::narrow_resp_t held;

    got       = '0;
    arrival   = 0;
    req       = txn;
    req_valid = 1'b1;
    waited    = 0;
    // The previous response may still be pending here
    while (!req_ready) begin
      step_cycle();
      waited++;
      if (waited > TimeoutCycles) begin
        $display("Timeout in %s: narrow_req_ready_o stayed low", where);
        timed_out = 1'b1;
        nr_errors++;
        return;
      end
    end
    // Request transfers on this edge
    step_cycle();
    accept_cycle = cycle_cnt;
    req_valid    = 1'b0;
    req          = '0;
    draw_bits(2, stalls);
    waited = 0;
    while (!resp_valid) begin
      step_cycle();
      waited++;
      if (waited > TimeoutCycles) begin
        $display("Timeout in %s: no response after the request was accepted", where);
        timed_out = 1'b1;
        nr_errors++;
        return;
      end
    end
    arrival = cycle_cnt + 1 - accept_cycle;
    if (stalls > 0) begin
      resp_ready = 1'b0;
      held       = resp;
      for (int s = 0; s < stalls; s++) begin
        step_cycle();
        if (!resp_valid || req_ready) begin
          $display("%s: handshake signals changed while the response was stalled", where);
          nr_errors++;
        end
        if (resp !== held) begin
          $display("FAIL %s narrow_resp_o expected 0x%h got 0x%h", where, held, resp);
          nr_errors++;
        end
      end
      resp_ready = 1'b1;
    end
    // Response transfers on the next edge, while the next request already waits
    got = resp;
  endtask

  initial begin
    mini_cluster_pkg::narrow_req_t  txn;
    mini_cluster_pkg::narrow_resp_t got;
    int unsigned                    row, base, arrival, errs_before;
    logic [31:0]                    exp_rdata, exp_err, exp_msip;
    string                          where;

    arst_n     = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    lfsr_q     = 16'd10501;
    cycle_cnt  = 0;
    nr_tests   = 0;
    nr_pass    = 0;
    nr_errors  = 0;
    timed_out  = 1'b0;
    $readmemh("test/narrow_input.txt", vectors);

    for (int i = 0; i < 8; i++) begin
      step_cycle();
    end
    arst_n = 1'b1;
    // Idle like the boot sequence before the first access
    for (int i = 0; i < 4; i++) begin
      step_cycle();
    end

    nr_tests++;
    errs_before = nr_errors;
    if (req_ready !== 1'b1) begin
      report_value_error("reset", "narrow_req_ready_o", 32'h1, 32'(req_ready));
    end
    if (resp_valid !== 1'b0) begin
      report_value_error("reset", "narrow_resp_valid_o", 32'h0, 32'(resp_valid));
    end
    if (msip !== '0) begin
      report_value_error("reset", "msip_o", 32'h0, 32'(msip));
    end
    report_test_result("reset state", errs_before);

    row = 0;
    while (!timed_out && (row < MaxRows) && (vectors[row*NrCols] != OpEnd)) begin
      base      = row * NrCols;
      txn.write = (vectors[base] == 32'h1);
      txn.addr  = vectors[base+1];
      txn.wdata = vectors[base+2];
      txn.strb  = vectors[base+3][mini_cluster_pkg::StrbWidth-1:0];
      exp_rdata = vectors[base+4];
      exp_err   = vectors[base+5];
      exp_msip  = vectors[base+6];
      where     = $sformatf("row %0d", row);
      nr_tests++;
      errs_before = nr_errors;
      do_transfer(txn, where, got, arrival);
      if (!timed_out) begin
        if (arrival != RespLatency) begin
          $display("%s: response came %0d cycles after acceptance instead of %0d",
                   where, arrival, RespLatency);
          nr_errors++;
        end
        if (got.rdata !== exp_rdata) begin
          report_value_error(where, "narrow_resp_o.rdata", exp_rdata, got.rdata);
        end
        if (got.error !== exp_err[0]) begin
          report_value_error(where, "narrow_resp_o.error", exp_err, 32'(got.error));
        end
        if (msip !== exp_msip[NrCores-1:0]) begin
          report_value_error(where, "msip_o", exp_msip, 32'(msip));
        end
      end
      report_test_result($sformatf("%s %s 0x%h", where, txn.write ? "write" : "read",
                                   txn.addr), errs_before);
      row++;
    end
    if (!timed_out && (row == MaxRows)) begin
      $display("The stimulus file has no end marker row");
      nr_errors++;
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             nr_tests, nr_pass, nr_tests - nr_pass, nr_errors);
    if (timed_out || (nr_errors != 0)) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mini_cluster.f
hdl/mini_cluster_pkg.sv
hdl/narrow_demux.sv
hdl/cluster_periph.sv
hdl/tcdm_sram.sv
hdl/mini_cluster.sv
test/mini_cluster_asserts.sv
test/testharness.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= testharness
FILELIST   ?= mini_cluster.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Testbench failed
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/narrow_input.txt
// op addr wdata strb exp_rdata exp_err exp_msip, all in hex
// op 0 reads, op 1 writes, op F ends the list
0 00010000 00000000 0 00000000 0 0
0 00010014 00000000 0 00000010 0 0
0 00010010 00000000 0 00000000 0 0
1 00010000 80001000 F 00000000 0 0
0 00010000 00000000 0 80001000 0 0
1 00010004 11223344 F 00000000 0 0
1 00010004 AABBCCDD 5 00000000 0 0
0 00010004 00000000 0 11BB33DD 0 0
1 00010008 00000005 F 00000000 0 5
0 00010010 00000000 0 00000005 0 5
1 0001000C 00000001 F 00000000 0 4
0 00010010 00000000 0 00000004 0 4
1 00010008 00000040 F 00000000 0 4
0 00010010 00000000 0 00000004 0 4
1 00000000 DEADBEEF F 00000000 0 4
1 00000004 01234567 F 00000000 0 4
1 00000004 89ABCDEF 3 00000000 0 4
1 000003FC CAFEF00D F 00000000 0 4
1 000003FC 00000099 1 00000000 0 4
0 00000000 00000000 0 DEADBEEF 0 4
0 00000004 00000000 0 0123CDEF 0 4
0 000003FC 00000000 0 CAFEF099 0 4
0 00000404 00000000 0 0123CDEF 0 4
1 00000C00 55AA55AA C 00000000 0 4
0 00000000 00000000 0 55AABEEF 0 4
0 00020000 00000000 0 00000000 1 4
1 00001000 FFFFFFFF F 00000000 1 4
1 00020008 0000000F F 00000000 1 4
0 00001004 00000000 0 00000000 1 4
0 00010000 00000000 0 80001000 0 4
0 00000000 00000000 0 55AABEEF 0 4
1 0001000C 0000000F F 00000000 0 0
0 00010018 00000000 0 00000000 0 0
F 00000000 00000000 0 00000000 0 0
